//--- design/stage_pkg.sv
`default_nettype none

package stage_pkg;

    localparam int score_w = 6;

    typedef enum logic [1:0] {
        stage_menu = 2'd0,
        stage_game = 2'd1,
        stage_over = 2'd2
    } stage_t;

    typedef enum logic {
        role_master = 1'b0,
        role_slave  = 1'b1
    } role_t;

    typedef enum logic [1:0] {
        msg_connect = 2'd0,
        msg_start   = 2'd1,
        msg_score   = 2'd2
    } msg_kind_t;

    // kind sits in the top two bits in both views.
    typedef union packed {
        struct packed {
            msg_kind_t  kind;
            role_t      role;  // role of the sender.
            logic [4:0] rsvd;
        } cmd;
        struct packed {
            msg_kind_t          kind;
            logic [score_w-1:0] score;
        } score;
    } link_word_t;

endpackage

`default_nettype wire

//--- design/click_pulse.sv
`timescale 1ns/1ps
`default_nettype none

module click_pulse (
    input  logic clk,
    input  logic reset,
    input  logic mouse_left,
    output logic click
);

    logic sync0;
    logic sync1;
    logic sync1_d;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync0   <= 1'b0;
            sync1   <= 1'b0;
            sync1_d <= 1'b0;
            click   <= 1'b0;
        end else begin
            sync0   <= mouse_left;  // async button input.
            sync1   <= sync0;
            sync1_d <= sync1;
            click   <= sync1 & ~sync1_d;  // rising edge only.
        end
    end

endmodule

`default_nettype wire

//--- design/button_hit.sv
`timescale 1ns/1ps
`default_nettype none

module button_hit #(
    parameter logic [9:0] start_x0   = 10'd270,
    parameter logic [9:0] start_x1   = 10'd370,
    parameter logic [9:0] start_y0   = 10'd260,
    parameter logic [9:0] start_y1   = 10'd300,
    parameter logic [9:0] connect_x0 = 10'd270,
    parameter logic [9:0] connect_x1 = 10'd370,
    parameter logic [9:0] connect_y0 = 10'd200,
    parameter logic [9:0] connect_y1 = 10'd240,
    parameter logic [9:0] return_x0  = 10'd270,
    parameter logic [9:0] return_x1  = 10'd370,
    parameter logic [9:0] return_y0  = 10'd320,
    parameter logic [9:0] return_y1  = 10'd360
) (
    input  logic [9:0] mouse_x,
    input  logic [9:0] mouse_y,
    input  logic       click,
    output logic       start_click,
    output logic       connect_click,
    output logic       return_click
);

    logic on_start;
    logic on_connect;
    logic on_return;

    // bounds are inclusive.
    assign on_start = (mouse_x >= start_x0) && (mouse_x <= start_x1)
                   && (mouse_y >= start_y0) && (mouse_y <= start_y1);
    assign on_connect = (mouse_x >= connect_x0) && (mouse_x <= connect_x1)
                     && (mouse_y >= connect_y0) && (mouse_y <= connect_y1);
    assign on_return = (mouse_x >= return_x0) && (mouse_x <= return_x1)
                    && (mouse_y >= return_y0) && (mouse_y <= return_y1);

    assign start_click   = click & on_start;
    assign connect_click = click & on_connect;
    assign return_click  = click & on_return;

endmodule

`default_nettype wire

//--- design/stage_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stage_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_click,
    input  logic                          connect_click,
    input  logic                          return_click,
    input  logic                          game_finish,
    input  logic [stage_pkg::score_w-1:0] score,
    input  logic                          recv_valid,
    input  stage_pkg::link_word_t         recv_word,
    output logic                          send_req,
    output stage_pkg::link_word_t         send_word,
    output stage_pkg::stage_t             stage,
    output stage_pkg::role_t              role,
    output logic                          linked,
    output logic [stage_pkg::score_w-1:0] peer_score,
    output logic                          game_init
);

    import stage_pkg::*;

    stage_t             stage_next;
    role_t              role_next;
    logic               peer_connect;
    logic               peer_connect_next;
    logic               sent_connect;
    logic               sent_connect_next;
    logic               send_next;
    link_word_t         word_next;
    logic [score_w-1:0] peer_score_next;
    logic               got_connect;
    logic               got_start;
    logic               got_score;

    assign got_connect = recv_valid && (recv_word.cmd.kind == msg_connect);
    assign got_start   = recv_valid && (recv_word.cmd.kind == msg_start);
    assign got_score   = recv_valid && (recv_word.score.kind == msg_score);

    assign game_init = (stage != stage_game);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage        <= stage_menu;
            role         <= role_master;
            peer_connect <= 1'b0;
            sent_connect <= 1'b0;
            linked       <= 1'b0;
            send_req     <= 1'b0;
            peer_score   <= '0;
        end else begin
            stage        <= stage_next;
            role         <= role_next;
            peer_connect <= peer_connect_next;
            sent_connect <= sent_connect_next;
            linked       <= sent_connect_next & peer_connect_next;  // both sides said hello.
            send_req     <= send_next;
            peer_score   <= peer_score_next;
        end
    end

    always_ff @(posedge clk) begin
        if (send_next) begin
            send_word <= word_next;
        end
    end

    always_comb begin
        stage_next        = stage;
        role_next         = role;
        peer_connect_next = peer_connect | got_connect;
        sent_connect_next = sent_connect;
        send_next         = 1'b0;
        word_next         = '0;
        peer_score_next   = peer_score;

        case (stage)
            stage_menu: begin
                if (connect_click) begin
                    // the later board to connect becomes the slave.
                    role_next          = peer_connect ? role_slave : role_master;
                    sent_connect_next  = 1'b1;
                    send_next          = 1'b1;
                    word_next.cmd.kind = msg_connect;
                    word_next.cmd.role = role_next;
                end else if (start_click && role == role_master) begin
                    stage_next         = stage_game;
                    send_next          = 1'b1;
                    word_next.cmd.kind = msg_start;
                    word_next.cmd.role = role;
                end else if (got_start && role == role_slave) begin
                    stage_next = stage_game;
                end
            end
            stage_game: begin
                if (game_finish) begin
                    stage_next            = stage_over;
                    send_next             = 1'b1;
                    word_next.score.kind  = msg_score;
                    word_next.score.score = score;
                end else if (linked && got_score) begin
                    stage_next      = stage_over;
                    peer_score_next = recv_word.score.score;
                end
            end
            stage_over: begin
                if (return_click) begin
                    stage_next        = stage_menu;
                    peer_connect_next = 1'b0;  // role is kept.
                    sent_connect_next = 1'b0;
                end
            end
            default: begin
                stage_next = stage_menu;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/link_port.sv
`timescale 1ns/1ps
`default_nettype none

module link_port #(
    parameter int bit_cycles = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  send_req,
    input  stage_pkg::link_word_t send_word,
    output logic                  tx,
    input  logic                  rx,
    output logic                  recv_valid,
    output stage_pkg::link_word_t recv_word
);

    import stage_pkg::*;

    localparam int cnt_w = (bit_cycles > 1) ? $clog2(bit_cycles) : 1;
    localparam logic [cnt_w-1:0] last_cyc = cnt_w'(bit_cycles - 1);
    localparam logic [cnt_w-1:0] mid_cyc = cnt_w'((bit_cycles >= 2) ? bit_cycles / 2 - 1 : 0);

    link_word_t       q_mem [2];
    logic             rd_ptr;
    logic             wr_ptr;
    logic [1:0]       q_count;
    logic             push;
    logic             pop;
    logic             bypass;

    logic             tx_busy;
    logic             tx_load;
    link_word_t       tx_word;
    logic [9:0]       tx_frame;
    logic [cnt_w-1:0] tx_cyc;
    logic [3:0]       tx_bits;

    logic             rx_s0;
    logic             rx_s1;
    logic             rx_busy;
    logic             rx_mid;
    logic [cnt_w-1:0] rx_cyc;
    logic [3:0]       rx_bits;
    logic [7:0]       rx_shift;

    assign tx_load = !tx_busy && (q_count != 2'd0 || send_req);
    assign bypass  = tx_load && (q_count == 2'd0);  // straight to the shifter.
    assign pop     = tx_load && (q_count != 2'd0);
    assign push    = send_req && !bypass && (q_count != 2'd2);  // full queue drops.
    assign tx_word = bypass ? send_word : q_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            q_mem[wr_ptr] <= send_word;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr  <= 1'b0;
            wr_ptr  <= 1'b0;
            q_count <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   q_count <= q_count + 2'd1;
                2'b01:   q_count <= q_count - 2'd1;
                default: q_count <= q_count;
            endcase
        end
    end

    // frame is {stop, data lsb first, start}, shifted out from bit 0.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_busy  <= 1'b0;
            tx_frame <= '1;
            tx_cyc   <= '0;
            tx_bits  <= 4'd0;
        end else if (tx_load) begin
            tx_busy  <= 1'b1;
            tx_frame <= {1'b1, tx_word, 1'b0};
            tx_cyc   <= '0;
            tx_bits  <= 4'd0;
        end else if (tx_busy) begin
            if (tx_cyc == last_cyc) begin
                tx_cyc   <= '0;
                tx_frame <= {1'b1, tx_frame[9:1]};  // idle ones fill in.
                tx_bits  <= tx_bits + 4'd1;
                if (tx_bits == 4'd9) begin
                    tx_busy <= 1'b0;
                end
            end else begin
                tx_cyc <= tx_cyc + cnt_w'(1);
            end
        end
    end

    assign tx = tx_frame[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_s0 <= 1'b1;
            rx_s1 <= 1'b1;
        end else begin
            rx_s0 <= rx;
            rx_s1 <= rx_s0;
        end
    end

    assign rx_mid = rx_busy && (rx_cyc == mid_cyc);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_busy    <= 1'b0;
            rx_cyc     <= '0;
            rx_bits    <= 4'd0;
            recv_valid <= 1'b0;
        end else begin
            recv_valid <= 1'b0;
            if (!rx_busy) begin
                if (!rx_s1) begin
                    rx_busy <= 1'b1;
                    rx_cyc  <= '0;
                    rx_bits <= 4'd0;
                end
            end else begin
                rx_cyc <= (rx_cyc == last_cyc) ? '0 : rx_cyc + cnt_w'(1);
                if (rx_mid) begin
                    rx_bits <= rx_bits + 4'd1;
                    if (rx_bits == 4'd0 && rx_s1) begin
                        rx_busy <= 1'b0;  // glitch, not a start bit.
                    end else if (rx_bits == 4'd9) begin
                        rx_busy    <= 1'b0;
                        recv_valid <= rx_s1;  // bad stop bit drops the byte.
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_mid && rx_bits >= 4'd1 && rx_bits <= 4'd8) begin
            rx_shift <= {rx_s1, rx_shift[7:1]};
        end
        if (rx_mid && rx_bits == 4'd9 && rx_s1) begin
            recv_word <= rx_shift;
        end
    end

endmodule

`default_nettype wire

//--- design/game_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_stage_top #(
    parameter int         bit_cycles = 4,
    parameter logic [9:0] start_x0   = 10'd270,
    parameter logic [9:0] start_x1   = 10'd370,
    parameter logic [9:0] start_y0   = 10'd260,
    parameter logic [9:0] start_y1   = 10'd300,
    parameter logic [9:0] connect_x0 = 10'd270,
    parameter logic [9:0] connect_x1 = 10'd370,
    parameter logic [9:0] connect_y0 = 10'd200,
    parameter logic [9:0] connect_y1 = 10'd240,
    parameter logic [9:0] return_x0  = 10'd270,
    parameter logic [9:0] return_x1  = 10'd370,
    parameter logic [9:0] return_y0  = 10'd320,
    parameter logic [9:0] return_y1  = 10'd360
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          mouse_left,
    input  logic [9:0]                    mouse_x,
    input  logic [9:0]                    mouse_y,
    input  logic                          game_finish,
    input  logic [stage_pkg::score_w-1:0] score,
    input  logic                          rx,
    output logic                          tx,
    output stage_pkg::stage_t             stage,
    output stage_pkg::role_t              role,
    output logic                          linked,
    output logic [stage_pkg::score_w-1:0] peer_score,
    output logic                          game_init
);

    import stage_pkg::*;

    logic       click;
    logic       start_click;
    logic       connect_click;
    logic       return_click;
    logic       send_req;
    logic       recv_valid;
    link_word_t send_word;
    link_word_t recv_word;

    click_pulse u_click (
        .clk        (clk),
        .reset      (reset),
        .mouse_left (mouse_left),
        .click      (click)
    );

    button_hit #(
        .start_x0   (start_x0),   .start_x1   (start_x1),
        .start_y0   (start_y0),   .start_y1   (start_y1),
        .connect_x0 (connect_x0), .connect_x1 (connect_x1),
        .connect_y0 (connect_y0), .connect_y1 (connect_y1),
        .return_x0  (return_x0),  .return_x1  (return_x1),
        .return_y0  (return_y0),  .return_y1  (return_y1)
    ) u_hit (
        .mouse_x       (mouse_x),
        .mouse_y       (mouse_y),
        .click         (click),
        .start_click   (start_click),
        .connect_click (connect_click),
        .return_click  (return_click)
    );

    stage_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start_click   (start_click),
        .connect_click (connect_click),
        .return_click  (return_click),
        .game_finish   (game_finish),
        .score         (score),
        .recv_valid    (recv_valid),
        .recv_word     (recv_word),
        .send_req      (send_req),
        .send_word     (send_word),
        .stage         (stage),
        .role          (role),
        .linked        (linked),
        .peer_score    (peer_score),
        .game_init     (game_init)
    );

    link_port #(
        .bit_cycles (bit_cycles)
    ) u_link (
        .clk        (clk),
        .reset      (reset),
        .send_req   (send_req),
        .send_word  (send_word),
        .tx         (tx),
        .rx         (rx),
        .recv_valid (recv_valid),
        .recv_word  (recv_word)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;  // free running.

endmodule

`default_nettype wire

//--- testbench/stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module stage_checker #(
    parameter int bit_cycles = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          tx,
    input  logic [1:0]                    stage,
    input  logic                          role,
    input  logic                          linked,
    input  logic [stage_pkg::score_w-1:0] peer_score,
    input  logic                          game_init,
    input  logic                          chk_req,
    input  logic [1:0]                    exp_stage,
    input  logic                          exp_role,
    input  logic                          exp_linked,
    input  logic [stage_pkg::score_w-1:0] exp_peer,
    input  logic                          exp_tx_req,
    input  logic [7:0]                    exp_tx_byte,
    input  logic                          chk_done,
    output int                            errors,
    output int                            tx_errors,
    output int                            tx_pending
);

    logic [7:0] exp_mem [16];  // expected tx bytes, in order.
    int         wr_idx;
    int         rd_idx;
    bit         dec_busy;

    assign tx_pending = wr_idx - rd_idx;

    task automatic compare_field(input string name, input logic [7:0] exp,
                                 input logic [7:0] got);
        if (exp !== got) begin
            $display("** Error %s: expected %02h, got %02h", name, exp, got);
            errors = errors + 1;
        end
    endtask

    always @(posedge clk) begin : compare_outputs
        int k;
        if (exp_tx_req) begin
            exp_mem[wr_idx % 16] <= exp_tx_byte;
            wr_idx               <= wr_idx + 1;
        end
        if (chk_req) begin
            compare_field("stage", 8'(exp_stage), 8'(stage));
            compare_field("role", 8'(exp_role), 8'(role));
            compare_field("linked", 8'(exp_linked), 8'(linked));
            compare_field("peer_score", 8'(exp_peer), 8'(peer_score));
            compare_field("game_init", 8'(exp_stage != 2'd1), 8'(game_init));
            // line must idle when nothing is in flight.
            if (wr_idx == rd_idx && !dec_busy && !exp_tx_req) begin
                compare_field("tx", 8'd1, 8'(tx));
            end
        end
        if (chk_done && wr_idx != rd_idx) begin
            for (k = rd_idx; k < wr_idx; k++) begin
                $display("tx byte %02h was expected but never arrived", exp_mem[k % 16]);
            end
            errors = errors + (wr_idx - rd_idx);
        end
    end

    // frames are sampled mid-bit, straight off the line.
    always begin : tx_decode
        logic [7:0] data;
        logic       bad;
        int         k;
        @(posedge clk);
        if (!reset && tx == 1'b0) begin
            dec_busy <= 1'b1;
            bad = 1'b0;
            repeat (bit_cycles / 2 - 1) @(posedge clk);
            if (tx !== 1'b0) begin
                bad = 1'b1;
            end
            for (k = 0; k < 8; k++) begin
                repeat (bit_cycles) @(posedge clk);
                data[k] = tx;
            end
            repeat (bit_cycles) @(posedge clk);
            if (tx !== 1'b1) begin
                bad = 1'b1;
            end
            if (bad) begin
                $display("tx frame with a broken start or stop bit");
                tx_errors <= tx_errors + 1;
            end else if (wr_idx == rd_idx) begin
                $display("tx byte %02h was sent but not expected", data);
                tx_errors <= tx_errors + 1;
            end else begin
                if (data !== exp_mem[rd_idx % 16]) begin
                    $display("** Error tx_byte: expected %02h, got %02h",
                             exp_mem[rd_idx % 16], data);
                    tx_errors <= tx_errors + 1;
                end
                rd_idx <= rd_idx + 1;
            end
            dec_busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- testbench/stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module stage_props (
    input logic       clk,
    input logic       reset,
    input logic       start_click,
    input logic       connect_click,
    input logic       recv_valid,
    input logic       send_req,
    input logic [1:0] stage,
    input logic       game_init,
    input logic       linked,
    input logic       peer_connect,
    input logic       sent_connect
);

    import stage_pkg::*;

    int pulse_fails;
    int code_fails;
    int init_fails;
    int link_fails;
    int fail_count;

    assign fail_count = pulse_fails + code_fails + init_fails + link_fails;

    send_pulse_a: assert property (@(posedge clk) disable iff (reset) send_req |=> !send_req)
        else begin
            $error("send_req stayed high for a second cycle");
            pulse_fails = pulse_fails + 1;
        end

    stage_code_a: assert property (@(posedge clk) disable iff (reset) stage != 2'd3)
        else begin
            $error("stage took the unused code 3");
            code_fails = code_fails + 1;
        end

    // game is entered from menu on a start click or a start message.
    game_init_a: assert property (@(posedge clk) disable iff (reset)
        $fell(game_init) |-> $past(stage == stage_menu && (start_click || recv_valid)))
        else begin
            $error("game_init fell without a start click or a received start");
            init_fails = init_fails + 1;
        end

    // linked rises only after both boards said hello.
    linked_a: assert property (@(posedge clk) disable iff (reset)
        $rose(linked) |-> $past(connect_click || sent_connect)
                          && $past(recv_valid || peer_connect))
        else begin
            $error("linked set without a connect from both boards");
            link_fails = link_fails + 1;
        end

endmodule

`default_nettype wire

//--- testbench/stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stage_tb;

    import stage_pkg::*;

    localparam int bit_cycles = 4;
    localparam int max_recs   = 64;

    logic               clk;
    logic               reset;
    logic               mouse_left;
    logic [9:0]         mouse_x;
    logic [9:0]         mouse_y;
    logic               game_finish;
    logic [score_w-1:0] score;
    logic               rx;
    logic               tx;
    logic [1:0]         stage;
    logic               role;
    logic               linked;
    logic [score_w-1:0] peer_score;
    logic               game_init;

    logic               chk_req;
    logic [1:0]         exp_stage;
    logic               exp_role;
    logic               exp_linked;
    logic [score_w-1:0] exp_peer;
    logic               exp_tx_req;
    logic [7:0]         exp_tx_byte;
    logic               chk_done;
    int                 val_errs;
    int                 tx_errs;
    int                 tx_pending;

    int recs [max_recs][9];  // act a1 a2 stage role linked peer txv txb.
    int n_recs;
    int tb_errs;
    int cycle_cnt;
    int timeout_limit = 0;

    tb_clock #(.period_ns(20)) clk_gen0 (.clk(clk));

    game_stage_top #(.bit_cycles(bit_cycles)) dut0 (
        .clk         (clk),
        .reset       (reset),
        .mouse_left  (mouse_left),
        .mouse_x     (mouse_x),
        .mouse_y     (mouse_y),
        .game_finish (game_finish),
        .score       (score),
        .rx          (rx),
        .tx          (tx),
        .stage       (stage),
        .role        (role),
        .linked      (linked),
        .peer_score  (peer_score),
        .game_init   (game_init)
    );

    stage_checker #(.bit_cycles(bit_cycles)) chk0 (
        .clk         (clk),
        .reset       (reset),
        .tx          (tx),
        .stage       (stage),
        .role        (role),
        .linked      (linked),
        .peer_score  (peer_score),
        .game_init   (game_init),
        .chk_req     (chk_req),
        .exp_stage   (exp_stage),
        .exp_role    (exp_role),
        .exp_linked  (exp_linked),
        .exp_peer    (exp_peer),
        .exp_tx_req  (exp_tx_req),
        .exp_tx_byte (exp_tx_byte),
        .chk_done    (chk_done),
        .errors      (val_errs),
        .tx_errors   (tx_errs),
        .tx_pending  (tx_pending)
    );

    bind stage_ctrl stage_props props0 (
        .clk           (clk),
        .reset         (reset),
        .start_click   (start_click),
        .connect_click (connect_click),
        .recv_valid    (recv_valid),
        .send_req      (send_req),
        .stage         (stage),
        .game_init     (game_init),
        .linked        (linked),
        .peer_connect  (peer_connect),
        .sent_connect  (sent_connect)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: the run did not end within %0d cycles", timeout_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic read_golden();
        int    fd;
        int    n;
        int    v [9];
        string line;
        fd = $fopen("testbench/stage_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/stage_golden.txt");
            tb_errs = tb_errs + 1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#" && n_recs < max_recs) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                                v[3], v[4], v[5], v[6], v[7], v[8]);
                    if (n == 9) begin
                        recs[n_recs] = v;
                        n_recs = n_recs + 1;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_recs == 0) begin
            $display("golden file holds no records");
            tb_errs = tb_errs + 1;
        end
    endtask

    task automatic drive_press(input logic [9:0] x, input logic [9:0] y);
        @(posedge clk);
        mouse_x    <= x;
        mouse_y    <= y;
        mouse_left <= 1'b1;
        repeat (2) @(posedge clk);
        mouse_left <= 1'b0;
        repeat (4) @(posedge clk);  // click lands 4 cycles after the press.
    endtask

    task automatic drive_rx(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        @(posedge clk);
        for (i = 0; i < 10; i++) begin
            rx <= frame[i];
            repeat (bit_cycles) @(posedge clk);
        end
        rx <= 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic drive_finish(input logic [score_w-1:0] sc);
        @(posedge clk);
        game_finish <= 1'b1;
        score       <= sc;
        @(posedge clk);
        game_finish <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic hand_check(input int i);
        chk_req     <= 1'b1;
        exp_stage   <= 2'(recs[i][3]);
        exp_role    <= 1'(recs[i][4]);
        exp_linked  <= 1'(recs[i][5]);
        exp_peer    <= score_w'(recs[i][6]);
        exp_tx_req  <= (recs[i][7] != 0);
        exp_tx_byte <= 8'(recs[i][8]);
        @(posedge clk);
        chk_req    <= 1'b0;
        exp_tx_req <= 1'b0;
    endtask

    initial begin : run_tests
        int i;
        int drain;
        int props_fails;
        reset       = 1'b1;
        mouse_left  = 1'b0;
        mouse_x     = 10'd0;
        mouse_y     = 10'd0;
        game_finish = 1'b0;
        score       = '0;
        rx          = 1'b1;
        chk_req     = 1'b0;
        exp_stage   = 2'd0;
        exp_role    = 1'b0;
        exp_linked  = 1'b0;
        exp_peer    = '0;
        exp_tx_req  = 1'b0;
        exp_tx_byte = 8'd0;
        chk_done    = 1'b0;
        read_golden();
        timeout_limit = n_recs * 60 + 200;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (i = 0; i < n_recs; i++) begin
            case (recs[i][0])
                0: repeat (recs[i][1]) @(posedge clk);
                1: drive_press(10'(recs[i][1]), 10'(recs[i][2]));
                2: drive_rx(8'(recs[i][1]));
                3: drive_finish(score_w'(recs[i][1]));
                default: begin
                    $display("record %0d has an unknown action %0d", i, recs[i][0]);
                    tb_errs = tb_errs + 1;
                end
            endcase
            hand_check(i);
        end
        drain = 0;
        while (tx_pending != 0 && drain < 30 * bit_cycles) begin
            @(posedge clk);
            drain = drain + 1;
        end
        chk_done <= 1'b1;
        @(posedge clk);
        chk_done <= 1'b0;
        @(posedge clk);
        props_fails = dut0.u_ctrl.props0.fail_count;
        $display("records %0d, value errors %0d, tx errors %0d, assertion failures %0d, other %0d",
                 n_recs, val_errs, tx_errs, props_fails, tb_errs);
        if (val_errs + tx_errs + props_fails + tb_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/stage_golden.txt
# act a1 a2 stage role linked peer_score tx_expected tx_byte, all hex
# act 0 waits a1 cycles, 1 presses at x=a1 y=a2, 2 sends byte a1 on rx, 3 finishes with score a1
0 004 000 0 0 0 00 0 00
1 00a 00a 0 0 0 00 0 00
1 140 0dc 0 0 0 00 1 00
2 020 000 0 0 1 00 0 00
1 140 118 1 0 1 00 1 40
3 02a 000 2 0 1 00 1 aa
1 140 154 0 0 0 00 0 00
2 000 000 0 0 0 00 0 00
1 140 0dc 0 1 1 00 1 20
1 140 118 0 1 1 00 0 00
2 040 000 1 1 1 00 0 00
2 095 000 2 1 1 15 0 00
1 140 154 0 1 0 15 0 00
1 140 0dc 0 0 0 15 1 00
1 140 118 1 0 0 15 1 40
3 03f 000 2 0 0 15 1 bf
0 080 000 2 0 0 15 0 00

//--- list.f
design/stage_pkg.sv
design/click_pulse.sv
design/button_hit.sv
design/stage_ctrl.sv
design/link_port.sv
design/game_stage_top.sv
testbench/tb_clock.sv
testbench/stage_checker.sv
testbench/stage_props.sv
testbench/stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the stage controller testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module stage_tb -o stage_sim -f list.f &&
./obj_dir/stage_sim | tee /dev/stderr | grep -q -x "Simulation passed" &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: build or simulation did not pass"; exit 1; }
